/* src/cnn_config.svh */
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// SRAM geometry
`define CNN_ADDR_W       12
`define CNN_DATA_W       16

// Pixel, kernel and accumulator widths
`define CNN_PIX_W        8
`define CNN_ACC_W        20
`define CNN_DIM_W        8

// Size word that ends a run
`define CNN_END_MARK     16'hffff

// Nine kernel bytes packed two per word
`define CNN_KERNEL_WORDS 5

// Clamp ceiling
`define CNN_RELU_MAX     127

`endif

/* src/cnn_pkg.sv */
`include "cnn_config.svh"

package cnn_pkg;

	typedef logic        [`CNN_ADDR_W-1:0] addr_t;
	typedef logic        [`CNN_DATA_W-1:0] word_t;
	typedef logic signed [`CNN_PIX_W-1:0]  pix_t;
	typedef logic signed [`CNN_ACC_W-1:0]  acc_t;
	typedef logic        [`CNN_DIM_W-1:0]  dim_t;

	// Input read sequencer
	typedef enum logic [2:0] {
		IDLE,
		READ_SIZE,
		CHECK_SIZE,
		READ_WIN,
		WAIT_SET,
		DONE
	} fetch_state_t;

	// Window buffer and multiply sequencer
	typedef enum logic [1:0] {
		EMPTY,
		FILL,
		MULT
	} conv_state_t;

endpackage

/* src/cnn_top.sv */
`timescale 1ns/1ps

module cnn_top import cnn_pkg::*; (
	input  logic  clk,
	input  logic  reset_b,
	input  logic  dut_run,
	output logic  dut_busy,
	output addr_t input_sram_read_address,
	input  word_t input_sram_read_data,
	output addr_t weights_sram_read_address,
	input  word_t weights_sram_read_data,
	output logic  output_sram_write_enable,
	output addr_t output_sram_write_address,
	output word_t output_sram_write_data
);

	logic win_valid;
	logic win_start;
	logic matrix_last;
	logic conv_idle;
	logic set_done;
	logic conv_valid;
	logic conv_last;
	logic out_done;
	acc_t sum0;
	acc_t sum1;
	acc_t sum2;
	acc_t sum3;

	window_fetch u_window_fetch (
		.clk                     (clk),
		.reset_b                 (reset_b),
		.dut_run                 (dut_run),
		.dut_busy                (dut_busy),
		.input_sram_read_address (input_sram_read_address),
		.input_sram_read_data    (input_sram_read_data),
		.conv_idle               (conv_idle),
		.set_done                (set_done),
		.out_done                (out_done),
		.win_valid               (win_valid),
		.win_start               (win_start),
		.matrix_last             (matrix_last)
	);

	conv_engine u_conv_engine (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.input_sram_read_data      (input_sram_read_data),
		.win_valid                 (win_valid),
		.win_start                 (win_start),
		.matrix_last               (matrix_last),
		.weights_sram_read_address (weights_sram_read_address),
		.weights_sram_read_data    (weights_sram_read_data),
		.conv_idle                 (conv_idle),
		.set_done                  (set_done),
		.conv_valid                (conv_valid),
		.conv_last                 (conv_last),
		.sum0                      (sum0),
		.sum1                      (sum1),
		.sum2                      (sum2),
		.sum3                      (sum3)
	);

	pool_relu_writer u_pool_relu_writer (
		.clk                        (clk),
		.reset_b                    (reset_b),
		.dut_busy                   (dut_busy),
		.conv_valid                 (conv_valid),
		.conv_last                  (conv_last),
		.sum0                       (sum0),
		.sum1                       (sum1),
		.sum2                       (sum2),
		.sum3                       (sum3),
		.output_sram_write_enable   (output_sram_write_enable),
		.output_sram_write_address  (output_sram_write_address),
		.output_sram_write_data     (output_sram_write_data),
		.out_done                   (out_done)
	);

endmodule

/* src/conv_engine.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module conv_engine import cnn_pkg::*; (
	input  logic  clk,
	input  logic  reset_b,
	input  word_t input_sram_read_data,
	input  logic  win_valid,
	input  logic  win_start,
	input  logic  matrix_last,
	output addr_t weights_sram_read_address,
	input  word_t weights_sram_read_data,
	output logic  conv_idle,
	output logic  set_done,
	output logic  conv_valid,
	output logic  conv_last,
	output acc_t  sum0,
	output acc_t  sum1,
	output acc_t  sum2,
	output acc_t  sum3
);

	// Index of k8
	localparam int LAST_TAP = 2 * `CNN_KERNEL_WORDS - 2;

	conv_state_t state;
	conv_state_t state_nxt;
	logic [3:0]  step;
	logic        data_valid;
	logic        data_first;
	logic        win_last;
	logic        push;
	logic        mult;
	logic        row_end;
	pix_t        kern;
	pix_t        win_buf [0:15];
	pix_t        tap [0:3];
	acc_t        acc [0:3];

	assign conv_idle = (state == EMPTY);
	assign mult      = (state == MULT);
	assign push      = data_valid && !mult;
	assign set_done  = mult && (step == 4'(LAST_TAP));
	assign row_end   = (step == 4'd2) || (step == 4'd5);

	// ----------------------------------------------------------------------
	// Kernel word is fetched one step ahead to cover the SRAM latency
	assign weights_sram_read_address = mult ? addr_t'((step + 4'd1) >> 1) : '0;
	assign kern = step[0] ? pix_t'(weights_sram_read_data[15:8])
		: pix_t'(weights_sram_read_data[7:0]);

	// Taps for the four convolution positions of the pool block
	assign tap[0] = win_buf[0];
	assign tap[1] = win_buf[1];
	assign tap[2] = win_buf[4];
	assign tap[3] = win_buf[5];

	assign sum0 = acc[0];
	assign sum1 = acc[1];
	assign sum2 = acc[2];
	assign sum3 = acc[3];

	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			EMPTY: begin
				if (data_first) state_nxt = FILL;
			end
			FILL: begin
				if (push && (step == 4'd7)) state_nxt = MULT;
			end
			MULT: begin
				if (set_done) state_nxt = EMPTY;
			end
			default: begin
				state_nxt = EMPTY;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state      <= EMPTY;
			step       <= '0;
			data_valid <= 1'b0;
			data_first <= 1'b0;
			win_last   <= 1'b0;
			conv_valid <= 1'b0;
			conv_last  <= 1'b0;
		end else begin
			state      <= state_nxt;
			data_valid <= win_valid;
			data_first <= win_start;
			conv_valid <= set_done;
			conv_last  <= set_done && win_last;
			if (win_start) win_last <= matrix_last;
			// First word lands in EMPTY, so fill counts from one
			if (state != state_nxt) begin
				step <= (state == EMPTY) ? 4'd1 : 4'd0;
			end else if (push || mult) begin
				step <= step + 4'd1;
			end
		end
	end

	// Row-major window with the oldest pair at index 0
	always_ff @(posedge clk) begin
		if (push || (mult && row_end)) begin
			for (int i = 0; i < 14; i++) begin
				win_buf[i] <= win_buf[i + 2];
			end
			if (push) begin
				win_buf[14] <= pix_t'(input_sram_read_data[7:0]);
				win_buf[15] <= pix_t'(input_sram_read_data[15:8]);
			end
		end else if (mult) begin
			for (int i = 0; i < 15; i++) begin
				win_buf[i] <= win_buf[i + 1];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < 4; j++) begin
			if (conv_idle) begin
				acc[j] <= '0;
			end else if (mult) begin
				acc[j] <= acc[j] + tap[j] * kern;
			end
		end
	end

endmodule

/* src/pool_relu_writer.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module pool_relu_writer import cnn_pkg::*; (
	input  logic  clk,
	input  logic  reset_b,
	input  logic  dut_busy,
	input  logic  conv_valid,
	input  logic  conv_last,
	input  acc_t  sum0,
	input  acc_t  sum1,
	input  acc_t  sum2,
	input  acc_t  sum3,
	output logic  output_sram_write_enable,
	output addr_t output_sram_write_address,
	output word_t output_sram_write_data,
	output logic  out_done
);

	localparam logic [`CNN_PIX_W-1:0] RELU_CEIL = `CNN_RELU_MAX;

	acc_t                  max_a;
	acc_t                  max_b;
	acc_t                  max_all;
	logic [`CNN_PIX_W-1:0] relu;
	logic [`CNN_PIX_W-1:0] relu_r;
	logic [`CNN_PIX_W-1:0] first_byte;
	logic                  res_valid;
	logic                  res_last;
	logic                  have_first;

	// 2x2 max pool
	assign max_a   = (sum0 > sum1) ? sum0 : sum1;
	assign max_b   = (sum2 > sum3) ? sum2 : sum3;
	assign max_all = (max_a > max_b) ? max_a : max_b;

	always_comb begin
		if (max_all < 0) begin
			relu = '0;
		end else if (max_all > `CNN_RELU_MAX) begin
			relu = RELU_CEIL;
		end else begin
			relu = max_all[`CNN_PIX_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (conv_valid) relu_r <= relu;
		if (res_valid && !have_first) first_byte <= relu_r;
	end

	// ----------------------------------------------------------------------
	// First result of a pair goes in the high byte
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			res_valid                  <= 1'b0;
			res_last                   <= 1'b0;
			have_first                 <= 1'b0;
			output_sram_write_enable   <= 1'b0;
			output_sram_write_address  <= '0;
			output_sram_write_data     <= '0;
			out_done                   <= 1'b0;
		end else begin
			res_valid                <= conv_valid;
			res_last                 <= conv_last;
			output_sram_write_enable <= 1'b0;
			out_done                 <= 1'b0;
			if (res_valid) begin
				if (have_first) begin
					output_sram_write_enable <= 1'b1;
					output_sram_write_data   <= {first_byte, relu_r};
					have_first               <= 1'b0;
				end else if (res_last) begin
					// Odd count pads the low byte
					output_sram_write_enable <= 1'b1;
					output_sram_write_data   <= {relu_r, {`CNN_PIX_W{1'b0}}};
				end else begin
					have_first <= 1'b1;
				end
				out_done <= res_last;
			end
			if (!dut_busy) begin
				output_sram_write_address <= '0;
			end else if (output_sram_write_enable) begin
				output_sram_write_address <= output_sram_write_address + addr_t'(1);
			end
		end
	end

endmodule

/* src/window_fetch.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module window_fetch import cnn_pkg::*; (
	input  logic  clk,
	input  logic  reset_b,
	input  logic  dut_run,
	output logic  dut_busy,
	output addr_t input_sram_read_address,
	input  word_t input_sram_read_data,
	input  logic  conv_idle,
	input  logic  set_done,
	input  logic  out_done,
	output logic  win_valid,
	output logic  win_start,
	output logic  matrix_last
);

	fetch_state_t state;
	fetch_state_t state_nxt;
	addr_t        base;
	addr_t        win_base;
	addr_t        rd_addr;
	dim_t         n_size;
	dim_t         last_pos;
	dim_t         row;
	dim_t         col;
	logic [2:0]   rd_cnt;
	logic [1:0]   pend;
	logic         last_win;
	logic         win_end;
	logic         matrix_issued;
	logic         drained;

	assign last_pos      = n_size - dim_t'(4);
	assign last_win      = (row == last_pos) && (col == last_pos);
	assign win_end       = (state == READ_WIN) && (rd_cnt == 3'd7);
	assign matrix_issued = win_end && last_win;

	// Matrices whose last write is still to come
	assign drained = (pend == 2'd0) || ((pend == 2'd1) && out_done);

	assign dut_busy    = (state != IDLE);
	assign win_valid   = (state == READ_WIN);
	assign win_start   = win_valid && (rd_cnt == 3'd0);
	assign matrix_last = win_valid && last_win;

	// ----------------------------------------------------------------------
	// Each window reads two words from each of four rows
	assign win_base = base + addr_t'(1)
		+ ((addr_t'(row) * addr_t'(n_size) + addr_t'(col)) >> 1);
	assign rd_addr  = win_base + addr_t'(rd_cnt[2:1]) * addr_t'(n_size >> 1)
		+ addr_t'(rd_cnt[0]);

	// Size word is read at the base and held there while waiting
	assign input_sram_read_address = win_valid ? rd_addr : base;

	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (dut_run) state_nxt = READ_SIZE;
			end
			READ_SIZE: begin
				state_nxt = CHECK_SIZE;
			end
			CHECK_SIZE: begin
				if (input_sram_read_data == `CNN_END_MARK) begin
					state_nxt = drained ? IDLE : DONE;
				end else if (conv_idle) begin
					state_nxt = READ_WIN;
				end
			end
			READ_WIN: begin
				if (rd_cnt == 3'd7) state_nxt = last_win ? READ_SIZE : WAIT_SET;
			end
			WAIT_SET: begin
				if (set_done) state_nxt = READ_WIN;
			end
			DONE: begin
				if (drained) state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state  <= IDLE;
			base   <= '0;
			row    <= '0;
			col    <= '0;
			rd_cnt <= '0;
			pend   <= '0;
		end else begin
			state <= state_nxt;
			if (state == IDLE) begin
				base   <= '0;
				row    <= '0;
				col    <= '0;
				rd_cnt <= '0;
				pend   <= '0;
			end else begin
				pend <= pend + {1'b0, matrix_issued} - {1'b0, out_done};
				if (win_valid) rd_cnt <= rd_cnt + 3'd1;
				// Pool blocks step by two in raster order
				if (win_end) begin
					if (col == last_pos) begin
						col <= '0;
						if (row == last_pos) begin
							row  <= '0;
							base <= base + ((addr_t'(n_size) * addr_t'(n_size)) >> 1)
								+ addr_t'(1);
						end else begin
							row <= row + dim_t'(2);
						end
					end else begin
						col <= col + dim_t'(2);
					end
				end
			end
		end
	end

	// N sits in the low byte of the size word
	always_ff @(posedge clk) begin
		if (state == CHECK_SIZE) n_size <= input_sram_read_data[`CNN_DIM_W-1:0];
	end

endmodule

/* tb.f */
+incdir+src
src/cnn_pkg.sv
src/window_fetch.sv
src/conv_engine.sv
src/pool_relu_writer.sv
src/cnn_top.sv
test/cnn_assertions.sv
test/cnn_tb.sv

/* test/cnn_assertions.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_assertions import cnn_pkg::*; (
	input logic  clk,
	input logic  reset_b,
	input logic  dut_run,
	input logic  dut_busy,
	input logic  output_sram_write_enable,
	input addr_t output_sram_write_address,
	input word_t output_sram_write_data,
	input addr_t weights_sram_read_address
);

	int fail_count = 0;

	// ----------------------------------------------------------------------
	reset_idle: assert property (@(posedge clk)
		!reset_b |=> !dut_busy && !output_sram_write_enable)
	else begin
		$error("busy or write enable high after reset");
		fail_count++;
	end

	run_start: assert property (@(posedge clk) disable iff (!reset_b)
		dut_run && !dut_busy |=> dut_busy)
	else begin
		$error("dut_busy did not rise after dut_run");
		fail_count++;
	end

	// One word per write with no gaps
	addr_step: assert property (@(posedge clk) disable iff (!reset_b)
		output_sram_write_enable |=>
		output_sram_write_address == $past(output_sram_write_address) + addr_t'(1))
	else begin
		$error("write address did not step by one");
		fail_count++;
	end

	byte_range: assert property (@(posedge clk) disable iff (!reset_b)
		output_sram_write_enable |-> output_sram_write_data[15:8] <= `CNN_RELU_MAX
		&& output_sram_write_data[7:0] <= `CNN_RELU_MAX)
	else begin
		$error("result byte above the clamp ceiling");
		fail_count++;
	end

	kernel_addr: assert property (@(posedge clk) disable iff (!reset_b)
		weights_sram_read_address < `CNN_KERNEL_WORDS)
	else begin
		$error("weights address out of range");
		fail_count++;
	end

endmodule

bind cnn_top cnn_assertions assert_i (
	.clk                       (clk),
	.reset_b                   (reset_b),
	.dut_run                   (dut_run),
	.dut_busy                  (dut_busy),
	.output_sram_write_enable  (output_sram_write_enable),
	.output_sram_write_address (output_sram_write_address),
	.output_sram_write_data    (output_sram_write_data),
	.weights_sram_read_address (weights_sram_read_address)
);

/* test/cnn_tb.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_tb import cnn_pkg::*; ();

	localparam int DATA_RANDOM = 0;
	localparam int DATA_HIGH   = 1;
	localparam int DATA_LOW    = 2;

	logic   clk;
	logic   reset_b;
	logic   dut_run;
	logic   dut_busy;
	addr_t  input_sram_read_address;
	word_t  input_sram_read_data;
	addr_t  weights_sram_read_address;
	word_t  weights_sram_read_data;
	logic   output_sram_write_enable;
	addr_t  output_sram_write_address;
	word_t  output_sram_write_data;

	word_t  mem_in [0:4095];
	word_t  w_mem [0:7];
	addr_t  wr_addr [$];
	word_t  wr_data [$];
	word_t  expected [$];
	integer seed = 32'h2295_e979;
	int     ptr;
	int     tests;
	int     failed;
	bit     hung;

	cnn_top dut_i (.*);

	always #10 clk = ~clk;

	// SRAM models with one cycle of read latency
	always @(posedge clk) begin
		input_sram_read_data   <= mem_in[input_sram_read_address];
		weights_sram_read_data <= w_mem[weights_sram_read_address[2:0]];
		if (output_sram_write_enable) begin
			wr_addr.push_back(output_sram_write_address);
			wr_data.push_back(output_sram_write_data);
		end
	end

	// ----------------------------------------------------------------------
	// Reference model
	function automatic int pixel(input int base, input int n, input int r, input int c);
		word_t w;
		w = mem_in[base + 1 + (r * n + c) / 2];
		return (c % 2) ? int'($signed(w[15:8])) : int'($signed(w[7:0]));
	endfunction

	function automatic int kernel_byte(input int i);
		word_t w;
		w = w_mem[i / 2];
		return (i % 2) ? int'($signed(w[15:8])) : int'($signed(w[7:0]));
	endfunction

	function automatic logic [7:0] pool_result(input int base, input int n,
		input int r, input int c);
		int best;
		int acc;
		best = -(1 << 30);
		for (int dr = 0; dr < 2; dr++) begin
			for (int dc = 0; dc < 2; dc++) begin
				acc = 0;
				for (int i = 0; i < 9; i++) begin
					acc += pixel(base, n, r + dr + i / 3, c + dc + i % 3) * kernel_byte(i);
				end
				if (acc > best) best = acc;
			end
		end
		if (best < 0) return 8'd0;
		if (best > `CNN_RELU_MAX) return 8'(`CNN_RELU_MAX);
		return 8'(best);
	endfunction

	// ----------------------------------------------------------------------
	// Memory image and expected words
	task automatic set_kernel(input int mode);
		logic [7:0] a;
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			a = (mode == DATA_RANDOM) ? 8'($random(seed)) : 8'h7f;
			b = (mode == DATA_RANDOM) ? 8'($random(seed)) : 8'h7f;
			w_mem[i] = (i < `CNN_KERNEL_WORDS) ? {b, a} : 16'h0000;
		end
	endtask

	task automatic add_matrix(input int n, input int mode);
		int         base;
		int         cnt;
		logic [7:0] hi;
		logic [7:0] res;
		logic [7:0] a;
		logic [7:0] b;
		base = ptr;
		cnt = 0;
		hi = '0;
		mem_in[base] = word_t'(n);
		for (int i = 0; i < n * n / 2; i++) begin
			a = (mode == DATA_HIGH) ? 8'h7f : (mode == DATA_LOW) ? 8'h80 : 8'($random(seed));
			b = (mode == DATA_HIGH) ? 8'h7f : (mode == DATA_LOW) ? 8'h80 : 8'($random(seed));
			mem_in[base + 1 + i] = {b, a};
		end
		ptr = base + 1 + n * n / 2;
		for (int r = 0; r <= n - 4; r += 2) begin
			for (int c = 0; c <= n - 4; c += 2) begin
				res = pool_result(base, n, r, c);
				if (cnt % 2 == 0) hi = res;
				else expected.push_back({hi, res});
				cnt++;
			end
		end
		if (cnt % 2) expected.push_back({hi, 8'h00});
	endtask

	task automatic new_image();
		ptr = 0;
		expected.delete();
	endtask

	// ----------------------------------------------------------------------
	// One run and its comparison
	task automatic run_test(input string name);
		int cycles;
		int errs;
		if (hung) return;
		tests++;
		errs = 0;
		mem_in[ptr] = `CNN_END_MARK;
		wr_addr.delete();
		wr_data.delete();
		@(negedge clk);
		dut_run = 1'b1;
		@(negedge clk);
		dut_run = 1'b0;
		cycles = 0;
		while (!dut_busy && cycles < 10) begin
			@(negedge clk);
			cycles++;
		end
		if (!dut_busy) begin
			$display("Test %s: timed out waiting for dut_busy to rise", name);
			failed++;
			return;
		end
		cycles = 0;
		while (dut_busy && cycles < 20000) begin
			@(negedge clk);
			cycles++;
		end
		if (dut_busy) begin
			$display("Test %s: timed out waiting for the run to finish", name);
			failed++;
			hung = 1'b1;
			return;
		end
		if (wr_data.size() != expected.size()) begin
			$display("Fail %s write count: expected %0d, actual %0d",
				name, expected.size(), wr_data.size());
			errs++;
		end
		for (int i = 0; i < wr_data.size() && i < expected.size(); i++) begin
			if (wr_addr[i] !== addr_t'(i)) begin
				$display("Fail %s address of write %0d: expected %0d, actual %0d",
					name, i, i, wr_addr[i]);
				errs++;
			end
			if (wr_data[i] !== expected[i]) begin
				$display("Fail %s word %0d: expected %h, actual %h",
					name, i, expected[i], wr_data[i]);
				errs++;
			end
		end
		if (errs != 0) failed++;
		$display("Test %s: %s", name, (errs == 0) ? "passed" : "failed");
	endtask

	// ----------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		reset_b = 1'b0;
		dut_run = 1'b0;
		input_sram_read_data = '0;
		weights_sram_read_data = '0;
		for (int a = 0; a < 4096; a++) begin
			mem_in[a] = {4'hc, 12'(a)};
		end
		repeat (3) @(negedge clk);
		reset_b = 1'b1;

		// Idle outputs straight after reset
		tests++;
		@(negedge clk);
		if (dut_busy !== 1'b0 || output_sram_write_enable !== 1'b0) begin
			$display("Fail reset busy/enable: expected 00, actual %b%b",
				dut_busy, output_sram_write_enable);
			failed++;
		end
		$display("Test reset: done");

		set_kernel(DATA_RANDOM);
		new_image();
		add_matrix(4, DATA_RANDOM);
		run_test("single_n4");

		new_image();
		add_matrix(8, DATA_RANDOM);
		add_matrix(6, DATA_RANDOM);
		run_test("n8_n6");

		set_kernel(DATA_HIGH);
		new_image();
		add_matrix(4, DATA_HIGH);
		add_matrix(4, DATA_LOW);
		run_test("clamp");

		new_image();
		run_test("terminator");

		set_kernel(DATA_RANDOM);
		new_image();
		add_matrix(6, DATA_RANDOM);
		add_matrix(4, DATA_RANDOM);
		run_test("rerun");

		repeat (4) @(negedge clk);
		$display("%0d tests, %0d failed, %0d assertion failures",
			tests, failed, dut_i.assert_i.fail_count);
		if (failed == 0 && dut_i.assert_i.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
